/* project.f */
+incdir+hw
+incdir+testbench
hw/cpu_pkg.sv
hw/alu_shifter.sv
hw/datapath.sv
hw/fetch_unit.sv
hw/cpu_controller.sv
hw/unified_ram.sv
hw/cpu_top.sv
testbench/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CPU regression with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f project.f --top-module tb_cpu \
    --Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_cpu_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

/* testbench/tb_asm.svh */
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// word layout is opcode, op, rn, rd, shift, rm (imm8 and imm5 overlay the low bits)
function automatic logic [15:0] mov_imm_word(input logic [2:0] rn, input logic [7:0] imm8);
    return {3'b110, 2'b10, rn, imm8};
endfunction

function automatic logic [15:0] mov_reg_word(input logic [2:0] rd, input logic [2:0] rm,
                                             input logic [1:0] sh);
    return {3'b110, 2'b00, 3'b000, rd, sh, rm};
endfunction

function automatic logic [15:0] alu_word(input logic [1:0] op, input logic [2:0] rd,
                                         input logic [2:0] rn, input logic [2:0] rm,
                                         input logic [1:0] sh);
    return {3'b101, op, rn, rd, sh, rm};
endfunction

function automatic logic [15:0] ldr_word(input logic [2:0] rd, input logic [2:0] rn,
                                         input logic [4:0] imm5);
    return {3'b011, 2'b00, rn, rd, imm5};
endfunction

function automatic logic [15:0] str_word(input logic [2:0] rd, input logic [2:0] rn,
                                         input logic [4:0] imm5);
    return {3'b100, 2'b00, rn, rd, imm5};
endfunction

function automatic logic [15:0] halt_word();
    return 16'hE000;
endfunction

// {n, v, z} for a - b, z first, then v, then n
function automatic logic [2:0] cmp_flags(input logic [15:0] a, input logic [15:0] b);
    logic [15:0] d;
    logic        ovf;
    d   = a - b;
    ovf = (a[15] != b[15]) && (d[15] != a[15]);
    if (d == 16'h0000)
        return 3'b001;
    else if (ovf)
        return 3'b010;
    else if (d[15])
        return 3'b100;
    return 3'b000;
endfunction

`endif

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module tb_cpu;
    `include "tb_asm.svh"

    logic        clk = 1'b0;
    logic        rst_n;
    logic [7:0]  start_pc;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [15:0] prog_data;
    logic [15:0] dut_out;
    logic [2:0]  dut_flags;  // n v z
    logic        dut_halted;

    int          errors;
    logic [31:0] lcg_state;
    logic [15:0] prog[$];
    string       cur_test = "none";
    logic        watch_en = 1'b0;
    int          watch_limit = 0;
    int          watch_cnt;

    always #5 clk = ~clk;

    cpu_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_pc  (start_pc),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out       (dut_out),
        .flags     (dut_flags),
        .halted    (dut_halted)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] shift_ref(input logic [15:0] v, input logic [1:0] sh);
        case (sh)
            2'b01:   return {v[14:0], 1'b0};
            2'b10:   return {1'b0, v[15:1]};
            2'b11:   return {v[15], v[15:1]};  // sign copied in
            default: return v;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flags(input logic [2:0] exp);
        assert (dut_flags === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t: flags expected %b actual %b", $time, exp, dut_flags);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1)
        else
        begin
            errors++;
            $display("at %0t in %s: %s", $time, cur_test, what);
        end
    endtask

    task automatic step(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic load_and_start(input logic [7:0] base);
        rst_n    = 1'b0;
        prog_we  = 1'b0;
        start_pc = base;
        step(1);
        foreach (prog[i])
        begin
            prog_we   = 1'b1;
            prog_addr = base + 8'(i);
            prog_data = prog[i];
            step(1);
        end
        prog_we = 1'b0;
        step(3);
        rst_n = 1'b1;
    endtask

    task automatic wait_halted();
        watch_limit = prog.size() * 13 + 20;  // str is the longest at 13 cycles
        watch_en    = 1'b1;
        while (dut_halted !== 1'b1)
            step(1);
        watch_en = 1'b0;
    endtask

    task automatic run_program(input logic [7:0] base);
        load_and_start(base);
        wait_halted();
    endtask

    // any 16-bit constant as (hi << 8) + sext(lo)
    task automatic emit_const(input logic [2:0] r, input logic [2:0] tmp, input logic [15:0] v);
        logic [7:0]  lo;
        logic [15:0] hi_part;
        lo      = v[7:0];
        hi_part = v - {{8{lo[7]}}, lo};
        prog.push_back(mov_imm_word(r, hi_part[15:8]));
        repeat (8)
            prog.push_back(mov_reg_word(r, r, 2'b01));
        prog.push_back(mov_imm_word(tmp, lo));
        prog.push_back(alu_word(2'b00, r, r, tmp, 2'b00));
    endtask

    task automatic test_move();
        logic [7:0]  imms [2];
        logic [31:0] r;
        logic [15:0] sx;
        logic [1:0]  sh;
        cur_test = "register move";
        r       = next_rand();
        imms[0] = 8'hA3;  // negative
        imms[1] = r[7:0];
        for (int i = 0; i < 2; i++)
        begin
            for (int s = 0; s < 4; s++)
            begin
                sh = 2'(s);
                prog.delete();
                prog.push_back(mov_imm_word(3'd1, imms[i]));
                prog.push_back(mov_reg_word(3'd2, 3'd1, sh));
                prog.push_back(halt_word());
                run_program(8'h00);
                sx = {{8{imms[i][7]}}, imms[i]};
                check_value("out", shift_ref(sx, sh), dut_out);
                check_flags(3'b000);
            end
        end
    endtask

    task automatic test_alu();
        logic [1:0]  ops [3];
        logic [31:0] r;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] exp;
        cur_test = "add and mvn";
        ops[0] = 2'b00;
        ops[1] = 2'b10;
        ops[2] = 2'b11;
        for (int k = 0; k < 6; k++)
        begin
            r = next_rand();
            a = r[15:0];
            b = r[31:16];
            prog.delete();
            emit_const(3'd1, 3'd7, a);
            emit_const(3'd2, 3'd7, b);
            prog.push_back(alu_word(ops[k % 3], 3'd3, 3'd1, 3'd2, 2'b00));
            prog.push_back(halt_word());
            run_program(8'h00);
            case (ops[k % 3])
                2'b00:   exp = a + b;
                2'b10:   exp = a & b;
                default: exp = ~b;
            endcase
            check_value("out", exp, dut_out);
            check_flags(3'b000);
        end
    endtask

    task automatic test_cmp();
        logic [15:0] pa [6];
        logic [15:0] pb [6];
        logic [31:0] r;
        cur_test = "cmp";
        pa[0] = 16'd1234;
        pb[0] = 16'd1234;  // equal
        pa[1] = 16'd5;
        pb[1] = 16'd100;   // negative
        pa[2] = 16'h7000;
        pb[2] = 16'h9000;  // positive overflow
        pa[3] = 16'h8000;
        pb[3] = 16'h0001;  // negative overflow
        for (int i = 4; i < 6; i++)
        begin
            r     = next_rand();
            pa[i] = r[15:0];
            pb[i] = r[31:16];
        end
        for (int i = 0; i < 6; i++)
        begin
            prog.delete();
            emit_const(3'd1, 3'd7, pa[i]);
            emit_const(3'd2, 3'd7, pb[i]);
            prog.push_back(alu_word(2'b01, 3'd3, 3'd1, 3'd2, 2'b00));
            prog.push_back(halt_word());
            run_program(8'h00);
            check_value("out", pa[i] - pb[i], dut_out);
            check_flags(cmp_flags(pa[i], pb[i]));
        end
    endtask

    task automatic test_mem();
        logic [4:0]  offs [2];
        logic [31:0] r;
        cur_test = "str then ldr";
        offs[0] = 5'h1D;  // -3
        offs[1] = 5'h07;
        for (int i = 0; i < 2; i++)
        begin
            r = next_rand();
            prog.delete();
            prog.push_back(mov_imm_word(3'd1, 8'hC8));  // low byte gives address 0xc8
            emit_const(3'd2, 3'd7, r[15:0]);
            prog.push_back(mov_imm_word(3'd4, 8'h00));
            prog.push_back(str_word(3'd2, 3'd1, offs[i]));
            prog.push_back(ldr_word(3'd4, 3'd1, offs[i]));
            prog.push_back(mov_reg_word(3'd5, 3'd4, 2'b00));
            prog.push_back(halt_word());
            run_program(8'h00);
            check_value("out", r[15:0], dut_out);
            check_flags(3'b000);
        end
    endtask

    task automatic test_start_halt();
        logic [31:0] r;
        logic [15:0] exp;
        cur_test = "start address and halt";
        r   = next_rand();
        exp = shift_ref({{8{r[7]}}, r[7:0]}, 2'b10);
        prog.delete();
        prog.push_back(mov_imm_word(3'd1, r[7:0]));
        prog.push_back(mov_reg_word(3'd2, 3'd1, 2'b10));
        prog.push_back(halt_word());
        run_program(8'h80);
        check_value("out", exp, dut_out);
        check_flags(3'b000);
        repeat (20)
        begin
            step(1);
            check_true("halted fell without reset", dut_halted);
            check_value("out", exp, dut_out);
        end
    endtask

    task automatic test_reset_mid();
        logic [31:0] r;
        logic [15:0] exp;
        cur_test = "reset during run";
        r   = next_rand();
        exp = shift_ref(r[15:0], 2'b11);
        prog.delete();
        emit_const(3'd1, 3'd7, r[15:0]);
        prog.push_back(mov_reg_word(3'd2, 3'd1, 2'b11));
        prog.push_back(halt_word());
        run_program(8'h40);
        check_value("out", exp, dut_out);
        rst_n = 1'b0;
        step(1);
        check_true("halted stayed high under reset", !dut_halted);
        step(2);
        rst_n = 1'b1;
        step(30);
        check_true("program ended too early", !dut_halted);
        rst_n = 1'b0;  // cut the run short
        step(3);
        rst_n = 1'b1;
        wait_halted();
        check_value("out", exp, dut_out);
        check_flags(3'b000);
    endtask

    initial
    begin
        watch_cnt = 0;
        while (!(watch_en && watch_cnt > watch_limit))
        begin
            @(posedge clk);
            if (watch_en)
                watch_cnt++;
            else
                watch_cnt = 0;
        end
        $display("timeout: test %s never raised halted within %0d cycles", cur_test, watch_limit);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        rst_n     = 1'b0;
        start_pc  = 8'h00;
        prog_we   = 1'b0;
        prog_addr = 8'h00;
        prog_data = 16'h0000;
        errors    = 0;
        lcg_state = 32'h0a2a3387;
        step(3);
        test_move();
        test_alu();
        test_cmp();
        test_mem();
        test_start_halt();
        test_reset_mid();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`CPU_ADDR_W-1:0] start_pc,
    input  wire logic                   prog_we,
    input  wire logic [`CPU_ADDR_W-1:0] prog_addr,
    input  wire logic [`CPU_DATA_W-1:0] prog_data,
    output logic      [`CPU_DATA_W-1:0] out,
    output cpu_pkg::flags_t             flags,
    output logic                        halted
);
    import cpu_pkg::*;

    ctrl_t                  ctrl;
    instr_t                 instr;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    logic [`CPU_DATA_W-1:0] mem_rdata;
    logic [`CPU_DATA_W-1:0] mem_wdata;

    cpu_controller u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .instr  (instr),
        .ctrl   (ctrl),
        .halted (halted)
    );

    fetch_unit u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .start_pc  (start_pc),
        .mem_rdata (mem_rdata),
        .c_value   (out),      // C feeds the data address register
        .mem_addr  (mem_addr),
        .instr     (instr)
    );

    datapath u_dp (
        .clk       (clk),
        .ctrl      (ctrl),
        .instr     (instr),
        .mem_rdata (mem_rdata),
        .out       (out),
        .flags     (flags),
        .mem_wdata (mem_wdata)
    );

    unified_ram u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .we        (ctrl.mem_we),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rdata     (mem_rdata)
    );

endmodule

`default_nettype wire

/* hw/unified_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module unified_ram (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`CPU_ADDR_W-1:0] addr,
    input  wire logic [`CPU_DATA_W-1:0] wdata,
    input  wire logic                   we,
    input  wire logic                   prog_we,
    input  wire logic [`CPU_ADDR_W-1:0] prog_addr,
    input  wire logic [`CPU_DATA_W-1:0] prog_data,
    output logic      [`CPU_DATA_W-1:0] rdata
);

    logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];
    logic                   wr_en;
    logic [`CPU_ADDR_W-1:0] wr_addr;
    logic [`CPU_DATA_W-1:0] wr_data;

    // loader owns the write port while in reset
    assign wr_en   = rst_n ? we    : prog_we;
    assign wr_addr = rst_n ? addr  : prog_addr;
    assign wr_data = rst_n ? wdata : prog_data;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rdata <= mem[addr];  // one cycle read latency
    end

    a_prog_only_in_reset: assert property (@(posedge clk) rst_n |-> !prog_we);

endmodule

`default_nettype wire

/* hw/cpu_controller.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu_controller (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire cpu_pkg::instr_t instr,
    output cpu_pkg::ctrl_t       ctrl,
    output logic                 halted
);
    import cpu_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        mov_imm;
    logic        is_mem;
    logic        is_cmp;

    assign mov_imm = (instr.op == ALU_AND);  // shares the and code
    assign is_mem  = (instr.opcode == OPC_LDR) || (instr.opcode == OPC_STR);
    assign is_cmp  = (instr.opcode == OPC_ALU) && (instr.op == ALU_CMP);
    assign halted  = (state == halt);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= start;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = halt;
        case (state)
            start:      state_nxt = pc_load;
            pc_load:    state_nxt = fetch_wait;
            pc_next:    state_nxt = fetch_wait;
            fetch_wait: state_nxt = ir_load;
            ir_load:    state_nxt = decode;
            decode:
            begin
                case (instr.opcode)
                    OPC_MOV: state_nxt = mov_imm ? write_back : read_b;
                    OPC_ALU: state_nxt = (instr.op == ALU_MVN) ? read_b : read_a;
                    OPC_LDR: state_nxt = read_a;
                    OPC_STR: state_nxt = read_a;
                    default: state_nxt = halt;  // halt and undefined codes
                endcase
            end
            write_back: state_nxt = pc_next;
            read_a:     state_nxt = is_mem ? exec : read_b;
            read_b:     state_nxt = exec;
            exec:
            begin
                if (is_mem)
                    state_nxt = addr_load;
                else if (is_cmp)
                    state_nxt = pc_next;  // nothing to write back
                else
                    state_nxt = write_back;
            end
            addr_load:  state_nxt = data_sel;
            data_sel:   state_nxt = data_wait;
            data_wait:  state_nxt = (instr.opcode == OPC_LDR) ? load_sel : str_read_b;
            load_sel:   state_nxt = write_back;
            str_read_b: state_nxt = str_exec;
            str_exec:   state_nxt = mem_write;
            mem_write:  state_nxt = write_wait;
            write_wait: state_nxt = pc_next;
            default:    state_nxt = halt;  // held until reset
        endcase
    end

    always_comb
    begin
        ctrl = '0;
        case (state)
            start:   ctrl.pc_restart = 1'b1;
            pc_load:
            begin
                ctrl.pc_load    = 1'b1;
                ctrl.pc_restart = 1'b1;
            end
            pc_next: ctrl.pc_load = 1'b1;
            ir_load: ctrl.ir_load = 1'b1;
            write_back:
            begin
                ctrl.reg_we  = 1'b1;
                ctrl.reg_sel = SEL_RD;
                if (instr.opcode == OPC_LDR)
                begin
                    ctrl.wb_sel        = WB_MEM;
                    ctrl.data_addr_sel = 1'b1;
                end
                else if (instr.opcode == OPC_MOV && mov_imm)
                begin
                    ctrl.reg_sel = SEL_RN;
                    ctrl.wb_sel  = WB_IMM8;
                end
            end
            read_a:
            begin
                ctrl.reg_sel = SEL_RN;
                ctrl.a_en    = 1'b1;
            end
            read_b:  ctrl.b_en = 1'b1;  // rm
            exec:
            begin
                ctrl.c_en       = 1'b1;
                ctrl.status_en  = 1'b1;
                ctrl.a_zero_sel = (instr.opcode == OPC_MOV);
                ctrl.b_imm_sel  = is_mem;  // rn + imm5
            end
            addr_load: ctrl.addr_load = 1'b1;
            data_sel, data_wait, load_sel: ctrl.data_addr_sel = 1'b1;
            str_read_b:
            begin
                ctrl.reg_sel = SEL_RD;
                ctrl.b_en    = 1'b1;
            end
            str_exec:
            begin
                ctrl.c_en       = 1'b1;
                ctrl.status_en  = 1'b1;
                ctrl.a_zero_sel = 1'b1;
            end
            mem_write:
            begin
                ctrl.mem_we        = 1'b1;
                ctrl.data_addr_sel = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // the store value must have reached C the cycle before the write
    a_mem_we_only_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.mem_we |-> (state == mem_write) && $past(ctrl.c_en));

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {start, pc_load, pc_next, fetch_wait, ir_load, decode,
                      write_back, read_a, read_b, exec, addr_load, data_sel,
                      data_wait, load_sel, str_read_b, str_exec, mem_write,
                      write_wait, halt});

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module fetch_unit (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire cpu_pkg::ctrl_t         ctrl,
    input  wire logic [`CPU_ADDR_W-1:0] start_pc,
    input  wire logic [`CPU_DATA_W-1:0] mem_rdata,
    input  wire logic [`CPU_DATA_W-1:0] c_value,
    output logic      [`CPU_ADDR_W-1:0] mem_addr,
    output cpu_pkg::instr_t             instr
);
    import cpu_pkg::*;

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] pc_nxt;
    logic [`CPU_DATA_W-1:0] ir;
    logic [`CPU_ADDR_W-1:0] data_addr;

    assign pc_nxt   = ctrl.pc_restart ? start_pc : pc + 1'b1;
    assign mem_addr = ctrl.data_addr_sel ? data_addr : pc;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc <= '0;
            ir <= '0;
        end
        else
        begin
            if (ctrl.pc_load)
                pc <= pc_nxt;
            if (ctrl.ir_load)
                ir <= mem_rdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.addr_load)
            data_addr <= c_value[`CPU_ADDR_W-1:0];  // low byte of rn + imm5
    end

    always_comb
    begin
        instr.opcode = opcode_e'(ir[`CPU_F_OPC]);
        instr.op     = alu_op_e'(ir[`CPU_F_OP]);
        instr.shift  = shift_e'(ir[`CPU_F_SHIFT]);
        instr.rn     = ir[`CPU_F_RN];
        instr.rd     = ir[`CPU_F_RD];
        instr.rm     = ir[`CPU_F_RM];
        instr.sximm8 = {{(`CPU_DATA_W - `CPU_IMM8_W){ir[`CPU_IMM8_W-1]}}, ir[`CPU_F_IMM8]};
        instr.sximm5 = {{(`CPU_DATA_W - `CPU_IMM5_W){ir[`CPU_IMM5_W-1]}}, ir[`CPU_F_IMM5]};
    end

endmodule

`default_nettype wire

/* hw/datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module datapath (
    input  wire logic                   clk,
    input  wire cpu_pkg::ctrl_t         ctrl,
    input  wire cpu_pkg::instr_t        instr,
    input  wire logic [`CPU_DATA_W-1:0] mem_rdata,
    output logic      [`CPU_DATA_W-1:0] out,
    output cpu_pkg::flags_t             flags,
    output logic      [`CPU_DATA_W-1:0] mem_wdata
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];
    logic [`CPU_REG_W-1:0]  reg_idx;
    logic [`CPU_DATA_W-1:0] rd_data;
    logic [`CPU_DATA_W-1:0] wb_data;
    logic [`CPU_DATA_W-1:0] a_reg;
    logic [`CPU_DATA_W-1:0] b_reg;
    logic [`CPU_DATA_W-1:0] c_reg;
    logic [`CPU_DATA_W-1:0] a_val;
    logic [`CPU_DATA_W-1:0] alu_result;
    flags_t                 alu_flags;
    flags_t                 status;

    // one index serves both read and write
    always_comb
    begin
        case (ctrl.reg_sel)
            SEL_RD:  reg_idx = instr.rd;
            SEL_RN:  reg_idx = instr.rn;
            default: reg_idx = instr.rm;
        endcase
    end

    always_comb
    begin
        case (ctrl.wb_sel)
            WB_IMM8: wb_data = instr.sximm8;
            WB_MEM:  wb_data = mem_rdata;
            default: wb_data = c_reg;
        endcase
    end

    assign rd_data = regs[reg_idx];

    always_ff @(posedge clk)
    begin
        if (ctrl.reg_we)
            regs[reg_idx] <= wb_data;
        if (ctrl.a_en)
            a_reg <= rd_data;
        if (ctrl.b_en)
            b_reg <= rd_data;
        if (ctrl.c_en)
            c_reg <= alu_result;
        if (ctrl.status_en)
            status <= alu_flags;
    end

    assign a_val = ctrl.a_zero_sel ? '0 : a_reg;

    alu_shifter u_alu (
        .b_in    (b_reg),
        .a_val   (a_val),
        .imm5    (instr.sximm5),
        .use_imm (ctrl.b_imm_sel),
        .shift   (instr.shift),
        .op      (instr.op),
        .opcode  (instr.opcode),
        .result  (alu_result),
        .flags   (alu_flags)
    );

    assign out       = c_reg;
    assign mem_wdata = c_reg;  // store data comes through C
    assign flags     = status;

    // write-back reads C, so both in one cycle would use a stale value
    a_no_wb_with_c_load: assert property (@(posedge clk) !(ctrl.reg_we && ctrl.c_en));

endmodule

`default_nettype wire

/* hw/alu_shifter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module alu_shifter (
    input  wire logic [`CPU_DATA_W-1:0] b_in,
    input  wire logic [`CPU_DATA_W-1:0] a_val,
    input  wire logic [`CPU_DATA_W-1:0] imm5,
    input  wire logic                   use_imm,
    input  wire cpu_pkg::shift_e        shift,
    input  wire cpu_pkg::alu_op_e       op,
    input  wire cpu_pkg::opcode_e       opcode,
    output logic      [`CPU_DATA_W-1:0] result,
    output cpu_pkg::flags_t             flags
);
    import cpu_pkg::*;

    localparam int W = `CPU_DATA_W;

    logic [W-1:0] shifted;
    logic [W-1:0] operand_b;
    logic [W-1:0] diff;
    logic         overflow;
    alu_op_e      eff_op;

    always_comb
    begin
        shifted = b_in;
        if (opcode != OPC_STR)  // store value passes unshifted
        begin
            case (shift)
                SH_LSL:  shifted = {b_in[W-2:0], 1'b0};
                SH_LSR:  shifted = {1'b0, b_in[W-1:1]};
                SH_ASR:  shifted = {b_in[W-1], b_in[W-1:1]};
                default: shifted = b_in;
            endcase
        end
    end

    assign operand_b = use_imm ? imm5 : shifted;
    assign eff_op    = (opcode == OPC_ALU) ? op : ALU_ADD;  // mov and mem ops add
    assign diff      = a_val - operand_b;
    assign overflow  = (a_val[W-1] ^ operand_b[W-1]) & (diff[W-1] ^ a_val[W-1]);

    always_comb
    begin
        flags = '0;
        case (eff_op)
            ALU_CMP:
            begin
                result = diff;
                if (diff == '0)
                    flags.z = 1'b1;
                else if (overflow)
                    flags.v = 1'b1;
                else if (diff[W-1])
                    flags.n = 1'b1;
            end
            ALU_AND: result = a_val & operand_b;
            ALU_MVN: result = ~operand_b;
            default: result = a_val + operand_b;
        endcase
    end

endmodule

`default_nettype wire

/* hw/cpu_pkg.sv */
`default_nettype none
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        OPC_LDR  = 3'b011,
        OPC_STR  = 3'b100,
        OPC_ALU  = 3'b101,
        OPC_MOV  = 3'b110,
        OPC_HALT = 3'b111
    } opcode_e;

    // mov immediate reuses the and code, mov register the add code
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_CMP = 2'b01,
        ALU_AND = 2'b10,
        ALU_MVN = 2'b11
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL  = 2'b01,
        SH_LSR  = 2'b10,
        SH_ASR  = 2'b11
    } shift_e;

    typedef enum logic [4:0] {
        start, pc_load, pc_next, fetch_wait, ir_load, decode, write_back,
        read_a, read_b, exec, addr_load, data_sel, data_wait, load_sel,
        str_read_b, str_exec, mem_write, write_wait, halt
    } ctrl_state_e;

    typedef enum logic [1:0] {
        SEL_RM = 2'b00,
        SEL_RD = 2'b01,
        SEL_RN = 2'b10
    } reg_sel_e;

    typedef enum logic [1:0] {
        WB_C    = 2'b00,
        WB_IMM8 = 2'b01,
        WB_MEM  = 2'b10
    } wb_sel_e;

    typedef struct packed {
        opcode_e                opcode;
        alu_op_e                op;
        shift_e                 shift;
        logic [`CPU_REG_W-1:0]  rn;
        logic [`CPU_REG_W-1:0]  rd;
        logic [`CPU_REG_W-1:0]  rm;
        logic [`CPU_DATA_W-1:0] sximm8;
        logic [`CPU_DATA_W-1:0] sximm5;
    } instr_t;

    typedef struct packed {
        reg_sel_e reg_sel;
        wb_sel_e  wb_sel;
        logic     reg_we;
        logic     a_en;
        logic     b_en;
        logic     c_en;
        logic     status_en;
        logic     a_zero_sel;
        logic     b_imm_sel;
        logic     ir_load;
        logic     pc_load;
        logic     pc_restart;
        logic     addr_load;
        logic     data_addr_sel;  // 1 puts the data address on the bus
        logic     mem_we;
    } ctrl_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
    } flags_t;

endpackage

`default_nettype wire

/* hw/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_DATA_W    16
`define CPU_ADDR_W    8
`define CPU_MEM_DEPTH 256
`define CPU_NREGS     8
`define CPU_REG_W     3

// instruction fields as msb:lsb
`define CPU_F_OPC     15:13
`define CPU_F_OP      12:11
`define CPU_F_RN      10:8
`define CPU_F_RD      7:5
`define CPU_F_SHIFT   4:3
`define CPU_F_RM      2:0
`define CPU_F_IMM8    7:0
`define CPU_F_IMM5    4:0
`define CPU_IMM8_W    8
`define CPU_IMM5_W    5

`endif
